// ==== flist.f ====
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/cpu_state_machine.sv
design/cpu_cycle_counter.sv
design/decoder.sv
design/register_file.sv
design/execution.sv
design/mem_access.sv
design/cpu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_cpu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_cpu_top.sv ====
`timescale 1ns/100ps

module tb_cpu_top;
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	localparam int    CNT_W     = CNT_W_DEF;
	localparam word_t START_ADR = 32'h0000_0100;
	localparam int    N_PROG    = 39;
	localparam int    N_ST      = 14;
	localparam int    N_EXEC    = 35; // three stores sit in taken branch or jump shadows
	localparam word_t QUIT_ADR  = START_ADR + 4 * (N_PROG - 2); // the last store
	localparam int    LIMIT     = N_PROG * 8 * 3 + 200;

	logic             clk;
	logic             i_rst_n, i_cpu_start, i_quit_cmd;
	word_t            i_cpu_start_adr;
	word_t            o_pc_data;
	logic             o_cpu_run_state;
	logic [CNT_W-1:0] o_cycle_cnt, o_instret_cnt;
	logic             o_i_read_req, o_d_read_req, o_d_write_req;
	word_t            o_i_read_adr, o_d_read_adr, o_d_write_adr, o_d_write_data;
	logic             i_read_valid, i_write_finish;
	word_t            i_read_data;

	word_t mem [0:511]; // 2 KB of words
	word_t prog [N_PROG];
	word_t exp_adr [N_ST];
	word_t exp_dat [N_ST];
	int    errors    = 0;
	int    st_idx    = 0;
	int    wait_cnt  = 0;
	bit    armed     = 1'b0;
	bit    fetch_seen = 1'b0;

	tb_clock_gen clock_gen (.o_clk(clk));

	cpu_top #(.CNT_W(CNT_W)) UUT (
		.i_clk(clk), .i_rst_n(i_rst_n),
		.i_cpu_start(i_cpu_start), .i_quit_cmd(i_quit_cmd),
		.i_cpu_start_adr(i_cpu_start_adr),
		.o_pc_data(o_pc_data), .o_cpu_run_state(o_cpu_run_state),
		.o_cycle_cnt(o_cycle_cnt), .o_instret_cnt(o_instret_cnt),
		.o_i_read_req(o_i_read_req), .o_i_read_adr(o_i_read_adr),
		.o_d_read_req(o_d_read_req), .o_d_read_adr(o_d_read_adr),
		.i_read_valid(i_read_valid), .i_read_data(i_read_data),
		.o_d_write_req(o_d_write_req), .o_d_write_adr(o_d_write_adr),
		.o_d_write_data(o_d_write_data), .i_write_finish(i_write_finish)
	);

	// instruction encoders, straight from the RV32I formats
	function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t i_type(int op, int imm, int rs1, int f3, int rd);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic word_t s_type(int imm, int rs2, int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t b_type(int f3, int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic word_t u_type(int imm20, int rd);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic word_t j_type(int off, int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic logic [8:0] mem_index(word_t adr);
		return adr[10:2];
	endfunction

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cnt(string name, logic [CNT_W-1:0] got, logic [CNT_W-1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic build_tables();
		prog[0]  = u_type(32'h12345, 1);             // x1 = 0x12345000
		prog[1]  = i_type(7'h13, 32'h67, 0, 0, 2);   // x2 = 0x67
		prog[2]  = r_type(0, 2, 1, 0, 3);            // x3 = x1 + x2
		prog[3]  = i_type(7'h13, 32'h400, 0, 0, 10); // x10 = data base
		prog[4]  = s_type(0, 3, 10);
		prog[5]  = r_type(32'h20, 1, 3, 0, 4);       // x4 = x3 - x1
		prog[6]  = s_type(4, 4, 10);
		prog[7]  = i_type(7'h13, -5, 0, 0, 5);       // x5 = -5
		prog[8]  = r_type(0, 2, 5, 2, 6);            // slt, -5 < 0x67
		prog[9]  = s_type(8, 6, 10);
		prog[10] = i_type(7'h13, -1, 2, 2, 7);       // slti, 0x67 < -1 is false
		prog[11] = s_type(12, 7, 10);
		prog[12] = r_type(0, 5, 3, 7, 8);            // and
		prog[13] = r_type(0, 5, 2, 6, 9);            // or
		prog[14] = r_type(0, 9, 8, 4, 11);           // xor
		prog[15] = s_type(16, 8, 10);
		prog[16] = s_type(20, 9, 10);
		prog[17] = s_type(24, 11, 10);
		prog[18] = i_type(7'h13, 32'h0f0, 3, 7, 12); // andi
		prog[19] = i_type(7'h13, 32'h505, 12, 6, 13); // ori
		prog[20] = i_type(7'h13, 32'h7ff, 13, 4, 14); // xori
		prog[21] = s_type(28, 14, 10);
		prog[22] = i_type(7'h13, 32'h55, 0, 0, 0);   // write to x0 is dropped
		prog[23] = s_type(32, 0, 10);
		prog[24] = s_type(36, 3, 10);
		prog[25] = i_type(7'h03, 36, 10, 2, 15);     // lw back the same word
		prog[26] = s_type(40, 15, 10);
		prog[27] = b_type(0, 2, 4, 8);               // beq taken
		prog[28] = s_type(44, 1, 10);
		prog[29] = b_type(1, 2, 4, 8);               // bne not taken
		prog[30] = s_type(44, 2, 10);
		prog[31] = b_type(1, 1, 2, 8);               // bne taken
		prog[32] = s_type(48, 1, 10);
		prog[33] = b_type(0, 1, 2, 8);               // beq not taken
		prog[34] = s_type(48, 12, 10);
		prog[35] = j_type(8, 16);                    // jal at 0x18c
		prog[36] = s_type(52, 1, 10);
		prog[37] = s_type(52, 16, 10);
		prog[38] = j_type(0, 0);                     // spin, never reached
		exp_adr = '{32'h400, 32'h404, 32'h408, 32'h40c, 32'h410, 32'h414, 32'h418,
			32'h41c, 32'h420, 32'h424, 32'h428, 32'h42c, 32'h430, 32'h434};
		exp_dat = '{32'h1234_5067, 32'h67, 32'h1, 32'h0, 32'h1234_5063, 32'hffff_ffff,
			32'hedcb_af9c, 32'h29a, 32'h0, 32'h1234_5067, 32'h1234_5067, 32'h67,
			32'h60, 32'h190};
	endtask

	// bus responder, 1 to 3 cycles of latency per request
	always @(negedge clk) begin
		i_read_valid   = 1'b0;
		i_write_finish = 1'b0;
		i_quit_cmd     = 1'b0;
		if (o_i_read_req && !fetch_seen) begin
			fetch_seen = 1'b1;
			check_word("o_i_read_adr", o_i_read_adr, START_ADR);
			check_word("o_pc_data", o_pc_data, START_ADR);
		end
		if (o_i_read_req && !armed && o_i_read_adr == QUIT_ADR)
			i_quit_cmd = 1'b1; // quit arrives mid-instruction, taken at its retire
		if (o_i_read_req || o_d_read_req || o_d_write_req) begin
			if (!armed) begin
				armed    = 1'b1;
				wait_cnt = $urandom % 3;
			end
			if (wait_cnt == 0) begin
				armed = 1'b0;
				if (o_i_read_req) begin
					i_read_data  = mem[mem_index(o_i_read_adr)];
					i_read_valid = 1'b1;
				end else if (o_d_read_req) begin
					i_read_data  = mem[mem_index(o_d_read_adr)];
					i_read_valid = 1'b1;
				end else begin
					if (st_idx >= N_ST) begin
						$display("unexpected store beyond the end of the table");
						errors++;
					end else begin
						check_word("o_d_write_adr", o_d_write_adr, exp_adr[st_idx]);
						check_word("o_d_write_data", o_d_write_data, exp_dat[st_idx]);
					end
					mem[mem_index(o_d_write_adr)] = o_d_write_data;
					i_write_finish = 1'b1;
					st_idx++;
				end
			end else begin
				wait_cnt--;
			end
		end
	end

	initial begin
		int k;
		void'($urandom(12));
		i_rst_n         = 1'b0;
		i_cpu_start     = 1'b0;
		i_quit_cmd      = 1'b0;
		i_cpu_start_adr = '0;
		i_read_valid    = 1'b0;
		i_read_data     = '0;
		i_write_finish  = 1'b0;
		for (k = 0; k < 512; k++)
			mem[k] = word_t'(k * 4) ^ 32'h5a5a_0000;
		build_tables();
		for (k = 0; k < N_PROG; k++)
			mem[mem_index(START_ADR) + k] = prog[k];

		repeat (4) @(negedge clk);
		i_rst_n = 1'b1;
		@(negedge clk);
		i_cpu_start     = 1'b1;
		i_cpu_start_adr = START_ADR;
		@(negedge clk);
		i_cpu_start = 1'b0;

		while (st_idx < N_ST)
			@(negedge clk);
		k = 0;
		while (o_cpu_run_state && k < 10) begin
			@(negedge clk);
			k++;
		end
		if (o_cpu_run_state) begin
			$display("core still running after the quit command");
			errors++;
		end
		repeat (3) @(negedge clk);
		check_cnt("o_instret_cnt", o_instret_cnt, N_EXEC);
		if (o_cycle_cnt < 4 * N_EXEC) begin
			$display("cycle count %0d is below four cycles per instruction", o_cycle_cnt);
			errors++;
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// watchdog
	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("timeout after %0d cycles, %0d of %0d stores seen", LIMIT, st_idx, N_ST);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter real PERIOD = 10.0
) (
	output logic o_clk
);

	initial o_clk = 1'b0;

	always #(PERIOD / 2.0) o_clk = ~o_clk; // 10 ns period

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top #(
	parameter int CNT_W = cpu_ctrl_pkg::CNT_W_DEF
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_cpu_start,
	input  logic               i_quit_cmd,
	input  cpu_isa_pkg::word_t i_cpu_start_adr,
	output cpu_isa_pkg::word_t o_pc_data,
	output logic               o_cpu_run_state,
	output logic [CNT_W-1:0]   o_cycle_cnt,
	output logic [CNT_W-1:0]   o_instret_cnt,
	output logic               o_i_read_req,
	output cpu_isa_pkg::word_t o_i_read_adr,
	output logic               o_d_read_req,
	output cpu_isa_pkg::word_t o_d_read_adr,
	input  logic               i_read_valid,
	input  cpu_isa_pkg::word_t i_read_data,
	output logic               o_d_write_req,
	output cpu_isa_pkg::word_t o_d_write_adr,
	output cpu_isa_pkg::word_t o_d_write_data,
	input  logic               i_write_finish
);
	import cpu_isa_pkg::*;

	logic     stat_imr, stat_idrfr, stat_ex, stat_dmrw;
	logic     imr_done, dmrw_done, retire;
	word_t    inst, imm, rs1_data, rs2_data;
	alu_op_t  alu_op;
	logic     cmd_alu_imm, cmd_ld, cmd_st, cmd_br, br_ne, cmd_jal, wbk_en;
	reg_adr_t rs1_adr, rs2_adr, rd_adr;
	word_t    alu_result_ma, st_data_ma;
	reg_adr_t rd_adr_ma, rd_adr_wb;
	logic     wbk_en_ma, cmd_ld_ma, cmd_st_ma, wbk_en_wb;
	word_t    wbk_data_wb;

	cpu_state_machine cpu_state_machine (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_cpu_start(i_cpu_start), .i_quit_cmd(i_quit_cmd),
		.i_imr_done(imr_done), .i_dmrw_done(dmrw_done),
		.o_cpu_run_state(o_cpu_run_state),
		.o_stat_pc(), // no block acts on the pc stage itself
		.o_stat_imr(stat_imr), .o_stat_idrfr(stat_idrfr),
		.o_stat_ex(stat_ex), .o_stat_dmrw(stat_dmrw),
		.o_retire(retire)
	);

	cpu_cycle_counter #(.CNT_W(CNT_W)) cpu_cycle_counter (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_run(o_cpu_run_state), .i_retire(retire),
		.o_cycle_cnt(o_cycle_cnt), .o_instret_cnt(o_instret_cnt)
	);

	decoder decoder (
		.i_inst(inst), .o_alu_op(alu_op), .o_cmd_alu_imm(cmd_alu_imm),
		.o_cmd_ld(cmd_ld), .o_cmd_st(cmd_st), .o_cmd_br(cmd_br), .o_br_ne(br_ne),
		.o_cmd_jal(cmd_jal), .o_wbk_en(wbk_en), .o_imm(imm),
		.o_rs1_adr(rs1_adr), .o_rs2_adr(rs2_adr), .o_rd_adr(rd_adr)
	);

	register_file register_file (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_stat_idrfr(stat_idrfr),
		.i_rs1_adr(rs1_adr), .i_rs2_adr(rs2_adr),
		.i_wbk_en_wb(wbk_en_wb), .i_rd_adr_wb(rd_adr_wb), .i_wbk_data_wb(wbk_data_wb),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
	);

	execution execution (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_cpu_start(i_cpu_start), .i_cpu_start_adr(i_cpu_start_adr),
		.i_stat_ex(stat_ex), .i_retire(retire),
		.i_alu_op(alu_op), .i_cmd_alu_imm(cmd_alu_imm),
		.i_cmd_ld(cmd_ld), .i_cmd_st(cmd_st), .i_cmd_br(cmd_br), .i_br_ne(br_ne),
		.i_cmd_jal(cmd_jal), .i_wbk_en(wbk_en), .i_imm(imm), .i_rd_adr(rd_adr),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
		.o_pc(o_pc_data), .o_alu_result(alu_result_ma), .o_st_data(st_data_ma),
		.o_rd_adr(rd_adr_ma), .o_wbk_en(wbk_en_ma),
		.o_cmd_ld(cmd_ld_ma), .o_cmd_st(cmd_st_ma)
	);

	mem_access mem_access (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_pc(o_pc_data),
		.i_stat_imr(stat_imr), .i_stat_dmrw(stat_dmrw),
		.i_cmd_ld(cmd_ld_ma), .i_cmd_st(cmd_st_ma),
		.i_alu_result(alu_result_ma), .i_st_data(st_data_ma),
		.i_rd_adr(rd_adr_ma), .i_wbk_en(wbk_en_ma),
		.i_read_valid(i_read_valid), .i_read_data(i_read_data),
		.i_write_finish(i_write_finish),
		.o_inst(inst), .o_imr_done(imr_done), .o_dmrw_done(dmrw_done),
		.o_i_read_req(o_i_read_req), .o_i_read_adr(o_i_read_adr),
		.o_d_read_req(o_d_read_req), .o_d_read_adr(o_d_read_adr),
		.o_d_write_req(o_d_write_req), .o_d_write_adr(o_d_write_adr),
		.o_d_write_data(o_d_write_data),
		.o_wbk_en_wb(wbk_en_wb), .o_rd_adr_wb(rd_adr_wb), .o_wbk_data_wb(wbk_data_wb)
	);

endmodule

// ==== design/mem_access.sv ====
`timescale 1ns/100ps

module mem_access (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  cpu_isa_pkg::word_t    i_pc,
	input  logic                  i_stat_imr,
	input  logic                  i_stat_dmrw,
	input  logic                  i_cmd_ld,
	input  logic                  i_cmd_st,
	input  cpu_isa_pkg::word_t    i_alu_result,
	input  cpu_isa_pkg::word_t    i_st_data,
	input  cpu_isa_pkg::reg_adr_t i_rd_adr,
	input  logic                  i_wbk_en,
	input  logic                  i_read_valid,
	input  cpu_isa_pkg::word_t    i_read_data,
	input  logic                  i_write_finish,
	output cpu_isa_pkg::word_t    o_inst,
	output logic                  o_imr_done,
	output logic                  o_dmrw_done,
	output logic                  o_i_read_req,
	output cpu_isa_pkg::word_t    o_i_read_adr,
	output logic                  o_d_read_req,
	output cpu_isa_pkg::word_t    o_d_read_adr,
	output logic                  o_d_write_req,
	output cpu_isa_pkg::word_t    o_d_write_adr,
	output cpu_isa_pkg::word_t    o_d_write_data,
	output logic                  o_wbk_en_wb,
	output cpu_isa_pkg::reg_adr_t o_rd_adr_wb,
	output cpu_isa_pkg::word_t    o_wbk_data_wb
);

	// fetch, held for the whole imr stage
	assign o_i_read_req = i_stat_imr;
	assign o_i_read_adr = i_pc;
	assign o_imr_done   = i_stat_imr & i_read_valid;

	// opcode 0 after reset decodes as a nop
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_inst <= '0;
		else if (o_imr_done)
			o_inst <= i_read_data;
	end

	// load and store, address and data stable since ex
	assign o_d_read_req   = i_stat_dmrw & i_cmd_ld;
	assign o_d_read_adr   = i_alu_result;
	assign o_d_write_req  = i_stat_dmrw & i_cmd_st;
	assign o_d_write_adr  = i_alu_result;
	assign o_d_write_data = i_st_data;

	// non-memory instructions leave dmrw after one cycle
	assign o_dmrw_done = i_stat_dmrw & (i_cmd_ld ? i_read_valid :
	                                    i_cmd_st ? i_write_finish : 1'b1);

	// write back on the last dmrw cycle
	assign o_wbk_en_wb   = o_dmrw_done & i_wbk_en;
	assign o_rd_adr_wb   = i_rd_adr;
	assign o_wbk_data_wb = i_cmd_ld ? i_read_data : i_alu_result;

endmodule

// ==== design/execution.sv ====
`timescale 1ns/100ps

module execution (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_cpu_start,
	input  cpu_isa_pkg::word_t    i_cpu_start_adr,
	input  logic                  i_stat_ex,
	input  logic                  i_retire,
	input  cpu_isa_pkg::alu_op_t  i_alu_op,
	input  logic                  i_cmd_alu_imm,
	input  logic                  i_cmd_ld,
	input  logic                  i_cmd_st,
	input  logic                  i_cmd_br,
	input  logic                  i_br_ne,
	input  logic                  i_cmd_jal,
	input  logic                  i_wbk_en,
	input  cpu_isa_pkg::word_t    i_imm,
	input  cpu_isa_pkg::reg_adr_t i_rd_adr,
	input  cpu_isa_pkg::word_t    i_rs1_data,
	input  cpu_isa_pkg::word_t    i_rs2_data,
	output cpu_isa_pkg::word_t    o_pc,
	output cpu_isa_pkg::word_t    o_alu_result,
	output cpu_isa_pkg::word_t    o_st_data,
	output cpu_isa_pkg::reg_adr_t o_rd_adr,
	output logic                  o_wbk_en,
	output logic                  o_cmd_ld,
	output logic                  o_cmd_st
);
	import cpu_isa_pkg::*;

	word_t opb;
	word_t alu_out;
	word_t pc_plus4;
	word_t next_pc;
	logic  taken;

	assign opb      = i_cmd_alu_imm ? i_imm : i_rs2_data;
	assign pc_plus4 = o_pc + 32'd4;
	assign taken    = i_cmd_jal | (i_cmd_br & ((i_rs1_data == i_rs2_data) ^ i_br_ne));

	always_comb begin
		case (i_alu_op)
			ALU_ADD:    alu_out = i_rs1_data + opb; // also ld/st address
			ALU_SUB:    alu_out = i_rs1_data - opb;
			ALU_AND:    alu_out = i_rs1_data & opb;
			ALU_OR:     alu_out = i_rs1_data | opb;
			ALU_XOR:    alu_out = i_rs1_data ^ opb;
			ALU_SLT:    alu_out = {31'd0, $signed(i_rs1_data) < $signed(opb)};
			ALU_PASS_B: alu_out = opb;
			default:    alu_out = '0;
		endcase
	end

	// pc moves only at start and at retire
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_pc <= '0;
		else if (i_cpu_start)
			o_pc <= i_cpu_start_adr;
		else if (i_retire)
			o_pc <= next_pc;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wbk_en <= 1'b0;
			o_cmd_ld <= 1'b0;
			o_cmd_st <= 1'b0;
		end else if (i_stat_ex) begin
			o_wbk_en <= i_wbk_en;
			o_cmd_ld <= i_cmd_ld;
			o_cmd_st <= i_cmd_st;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_stat_ex) begin
			o_alu_result <= i_cmd_jal ? pc_plus4 : alu_out; // jal links pc+4
			o_st_data    <= i_rs2_data;
			o_rd_adr     <= i_rd_adr;
			next_pc      <= taken ? o_pc + i_imm : pc_plus4;
		end
	end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/100ps

module register_file (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_stat_idrfr,
	input  cpu_isa_pkg::reg_adr_t i_rs1_adr,
	input  cpu_isa_pkg::reg_adr_t i_rs2_adr,
	input  logic                  i_wbk_en_wb,
	input  cpu_isa_pkg::reg_adr_t i_rd_adr_wb,
	input  cpu_isa_pkg::word_t    i_wbk_data_wb,
	output cpu_isa_pkg::word_t    o_rs1_data,
	output cpu_isa_pkg::word_t    o_rs2_data
);
	import cpu_isa_pkg::*;

	word_t regs [0:31];

	always_ff @(posedge i_clk) begin
		if (i_wbk_en_wb && i_rd_adr_wb != '0)
			regs[i_rd_adr_wb] <= i_wbk_data_wb; // x0 stays zero
	end

	// operands captured once per instruction
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rs1_data <= '0;
			o_rs2_data <= '0;
		end else if (i_stat_idrfr) begin
			o_rs1_data <= (i_rs1_adr == '0) ? '0 : regs[i_rs1_adr];
			o_rs2_data <= (i_rs2_adr == '0) ? '0 : regs[i_rs2_adr];
		end
	end

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/100ps

module decoder (
	input  cpu_isa_pkg::word_t    i_inst,
	output cpu_isa_pkg::alu_op_t  o_alu_op,
	output logic                  o_cmd_alu_imm,
	output logic                  o_cmd_ld,
	output logic                  o_cmd_st,
	output logic                  o_cmd_br,
	output logic                  o_br_ne,
	output logic                  o_cmd_jal,
	output logic                  o_wbk_en,
	output cpu_isa_pkg::word_t    o_imm,
	output cpu_isa_pkg::reg_adr_t o_rs1_adr,
	output cpu_isa_pkg::reg_adr_t o_rs2_adr,
	output cpu_isa_pkg::reg_adr_t o_rd_adr
);
	import cpu_isa_pkg::*;

	logic [6:0] opcode;
	logic [2:0] f3;
	word_t      imm_i, imm_s, imm_b, imm_j, imm_u;

	assign opcode    = i_inst[6:0];
	assign f3        = i_inst[14:12];
	assign o_rs1_adr = i_inst[19:15];
	assign o_rs2_adr = i_inst[24:20];
	assign o_rd_adr  = i_inst[11:7];

	// sign extended immediates
	assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
	assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
	assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
	assign imm_u = {i_inst[31:12], 12'd0};

	always_comb begin
		o_alu_op      = ALU_ADD;
		o_cmd_alu_imm = 1'b0;
		o_cmd_ld      = 1'b0;
		o_cmd_st      = 1'b0;
		o_cmd_br      = 1'b0;
		o_br_ne       = 1'b0;
		o_cmd_jal     = 1'b0;
		o_wbk_en      = 1'b0;
		o_imm         = imm_i;
		case (opcode)
			OP_LUI: begin
				o_alu_op      = ALU_PASS_B;
				o_cmd_alu_imm = 1'b1;
				o_wbk_en      = 1'b1;
				o_imm         = imm_u;
			end
			OP_ALUI, OP_ALU: begin
				o_cmd_alu_imm = (opcode == OP_ALUI);
				o_wbk_en      = 1'b1;
				case (f3)
					F3_ADD: o_alu_op = (opcode == OP_ALU && i_inst[30]) ? ALU_SUB : ALU_ADD;
					F3_SLT: o_alu_op = ALU_SLT;
					F3_XOR: o_alu_op = ALU_XOR;
					F3_OR:  o_alu_op = ALU_OR;
					F3_AND: o_alu_op = ALU_AND;
					default: o_wbk_en = 1'b0; // shifts etc, treated as nop
				endcase
			end
			OP_LD: begin
				o_cmd_alu_imm = 1'b1;
				o_cmd_ld      = (f3 == F3_LW); // word loads only
				o_wbk_en      = (f3 == F3_LW);
			end
			OP_ST: begin
				o_cmd_alu_imm = 1'b1;
				o_cmd_st      = (f3 == F3_SW);
				o_imm         = imm_s;
			end
			OP_BR: begin
				o_cmd_br = (f3 == F3_BEQ) | (f3 == F3_BNE);
				o_br_ne  = (f3 == F3_BNE);
				o_imm    = imm_b;
			end
			OP_JAL: begin
				o_cmd_jal = 1'b1;
				o_wbk_en  = 1'b1; // link register
				o_imm     = imm_j;
			end
			default: ; // unknown opcode, no strobes
		endcase
	end

endmodule

// ==== design/cpu_cycle_counter.sv ====
`timescale 1ns/100ps

module cpu_cycle_counter #(
	parameter int CNT_W = cpu_ctrl_pkg::CNT_W_DEF
) (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_run,
	input  logic             i_retire,
	output logic [CNT_W-1:0] o_cycle_cnt,
	output logic [CNT_W-1:0] o_instret_cnt
);

	// both hold their value while idle
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cycle_cnt   <= '0;
			o_instret_cnt <= '0;
		end else begin
			if (i_run)
				o_cycle_cnt <= o_cycle_cnt + 1'b1;
			if (i_retire)
				o_instret_cnt <= o_instret_cnt + 1'b1; // one per instruction
		end
	end

endmodule

// ==== design/cpu_state_machine.sv ====
`timescale 1ns/100ps

module cpu_state_machine (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_cpu_start,
	input  logic i_quit_cmd,
	input  logic i_imr_done,
	input  logic i_dmrw_done,
	output logic o_cpu_run_state,
	output logic o_stat_pc,
	output logic o_stat_imr,
	output logic o_stat_idrfr,
	output logic o_stat_ex,
	output logic o_stat_dmrw,
	output logic o_retire
);
	import cpu_ctrl_pkg::*;

	cpu_stat_t stat;
	cpu_stat_t stat_nxt;
	logic      quit_pend; // quit seen, waiting for retire

	assign o_retire = (stat == DMRW) & i_dmrw_done;

	always_comb begin
		stat_nxt = stat;
		case (stat)
			IDLE:  if (i_cpu_start) stat_nxt = PC;
			PC:    stat_nxt = IMR;
			IMR:   if (i_imr_done) stat_nxt = IDRFR; // waits on fetch latency
			IDRFR: stat_nxt = EX;
			EX:    stat_nxt = DMRW;
			DMRW:  if (i_dmrw_done) stat_nxt = (quit_pend | i_quit_cmd) ? IDLE : PC;
			default: stat_nxt = IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			stat      <= IDLE;
			quit_pend <= 1'b0;
		end else begin
			stat <= stat_nxt;
			if (o_retire)
				quit_pend <= 1'b0;
			else if (i_quit_cmd && stat != IDLE)
				quit_pend <= 1'b1;
		end
	end

	// one-hot stage strobes
	assign o_cpu_run_state = (stat != IDLE);
	assign o_stat_pc       = (stat == PC);
	assign o_stat_imr      = (stat == IMR);
	assign o_stat_idrfr    = (stat == IDRFR);
	assign o_stat_ex       = (stat == EX);
	assign o_stat_dmrw     = (stat == DMRW);

endmodule

// ==== design/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

	// stages of one instruction, exactly one in flight
	typedef enum logic [2:0] {
		IDLE  = 3'd0, // core stopped
		PC    = 3'd1, // pc valid for fetch
		IMR   = 3'd2, // instruction memory read
		IDRFR = 3'd3, // decode and register read
		EX    = 3'd4, // alu and next pc
		DMRW  = 3'd5  // data memory and write back
	} cpu_stat_t;

	localparam int CNT_W_DEF = 32; // cycle and instret counter width

endpackage

// ==== design/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	typedef logic [31:0] word_t; // data, address or instruction
	typedef logic [4:0]  reg_adr_t;

	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_SLT    = 3'd5,
		ALU_PASS_B = 3'd6  // lui, operand b straight through
	} alu_op_t;

	// major opcodes
	localparam logic [6:0] OP_LUI  = 7'b0110111;
	localparam logic [6:0] OP_ALUI = 7'b0010011;
	localparam logic [6:0] OP_ALU  = 7'b0110011;
	localparam logic [6:0] OP_LD   = 7'b0000011;
	localparam logic [6:0] OP_ST   = 7'b0100011;
	localparam logic [6:0] OP_BR   = 7'b1100011;
	localparam logic [6:0] OP_JAL  = 7'b1101111;

	// funct3 values
	localparam logic [2:0] F3_ADD = 3'b000; // also sub
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_SW  = 3'b010;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

endpackage
